/* flist.f */
+incdir+hdl
hdl/twiddle_pkg.sv
hdl/phase_divider.sv
hdl/cordic_twiddle_gen.sv
hdl/twiddle_powers.sv
hdl/sample_delay.sv
hdl/complex_rotator.sv
hdl/twiddle_stage.sv
bench/twiddle_stage_checker.sv
bench/twiddle_stage_tb.sv

/* Makefile */
VERILATOR  = verilator
TOP        = twiddle_stage_tb
FLIST      = flist.f
OBJ_DIR    = obj_dir
LOG        = sim.log
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

# the log decides pass or fail, not the simulator's exit status
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/twiddle_stage_tb.sv */
`timescale 1ns/1ps
`include "twiddle_config.svh"

module twiddle_stage_tb
	import twiddle_pkg::*;
();

	localparam int   PERIOD      = 4;
	localparam int   RST_CYCLES  = 3;
	localparam int   NUM_ENTRIES = 24;
	localparam real  PI          = 3.14159265358979323846;
	localparam logic FIXED       = 1'b0;
	localparam logic RANDOM      = 1'b1;

	typedef struct packed {
		tw_index_t  k;
		tw_index_t  n;
		logic [3:0] gap;
		logic       rand_mode;
	} entry_t;

	typedef struct packed {
		int          due;
		tw_index_t   k;
		tw_index_t   n;
		sample_vec_t din;
	} pending_t;

	// k, N, idle cycles after the vector, sample mode
	localparam entry_t STIM [NUM_ENTRIES] = '{
		'{12'd0,    12'd5,    4'd2, FIXED},  '{12'd0,    12'd125,  4'd0, RANDOM},
		'{12'd0,    12'd4000, 4'd1, RANDOM}, '{12'd1,    12'd4,    4'd0, RANDOM},
		'{12'd2,    12'd4,    4'd0, RANDOM}, '{12'd2,    12'd8,    4'd3, RANDOM},
		'{12'd4,    12'd8,    4'd0, RANDOM}, '{12'd3,    12'd12,   4'd0, RANDOM},
		'{12'd6,    12'd12,   4'd2, RANDOM}, '{12'd7,    12'd25,   4'd0, RANDOM},
		'{12'd11,   12'd125,  4'd0, RANDOM}, '{12'd7,    12'd25,   4'd1, FIXED},
		'{12'd1,    12'd5,    4'd0, RANDOM}, '{12'd2,    12'd5,    4'd0, RANDOM},
		'{12'd3,    12'd5,    4'd0, RANDOM}, '{12'd4,    12'd5,    4'd0, RANDOM},
		'{12'd999,  12'd1000, 4'd4, RANDOM}, '{12'd4094, 12'd4095, 4'd0, RANDOM},
		'{12'd1,    12'd3,    4'd0, RANDOM}, '{12'd123,  12'd640,  4'd0, RANDOM},
		'{12'd5,    12'd7,    4'd3, FIXED},  '{12'd17,   12'd32,   4'd0, RANDOM},
		'{12'd2047, 12'd4095, 4'd0, RANDOM}, '{12'd11,   12'd125,  4'd5, RANDOM}
	};

	logic        clk;
	logic        rst_n;
	logic        in_val;
	tw_index_t   twdl_k;
	tw_index_t   twdl_n;
	sample_vec_t din;
	logic        out_val;
	sample_vec_t dout;
	pending_t    pending [$];

	twiddle_stage twiddle_stage_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.in_val  (in_val),
		.twdl_k  (twdl_k),
		.twdl_n  (twdl_n),
		.din     (din),
		.out_val (out_val),
		.dout    (dout)
	);

	bind twiddle_stage twiddle_stage_checker u_checker (
		.clk     (clk),
		.rst_n   (rst_n),
		.in_val  (in_val),
		.out_val (out_val),
		.dout    (dout)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	function automatic int total_gaps();
		int sum;
		sum = 0;
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			sum += int'(STIM[i].gap);
		end
		return sum;
	endfunction

	// 29-bit samples so a rotated value still fits in DATA_W
	function automatic sample_t rand_sample();
		logic [31:0] r;
		r = $urandom;
		return sample_t'($signed(r[`DATA_W-2:0]));
	endfunction

	function automatic sample_vec_t make_vector(int idx, logic rand_mode);
		sample_vec_t v;
		for (int m = 0; m < `LANES; m++) begin
			if (rand_mode) begin
				v[m].re = rand_sample();
				v[m].im = rand_sample();
			end else begin
				v[m].re = sample_t'((idx + 1) * 40000 * (m + 1));
				v[m].im = sample_t'(-(idx + 7) * 31000 * (m + 1));
			end
		end
		return v;
	endfunction

	// phase as floor(k * 2^16 / N) in units of 2^-16 turn
	function automatic int expected_phase(tw_index_t k, tw_index_t n);
		longint num;
		num = longint'(k) * (longint'(1) << `PHASE_W);
		return int'(num / longint'(n));
	endfunction

	task automatic compare_exact(string name, cplx_sample_t got, cplx_sample_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got re=%0d im=%0d, expected re=%0d im=%0d",
				$time, name, got.re, got.im, exp.re, exp.im);
			abort_run();
		end
	endtask

	task automatic compare_near(string name, sample_t got, real exp, real tol);
		real diff;
		diff = real'(got) - exp;
		if (diff < 0.0) begin
			diff = -diff;
		end
		if ($isunknown(got) || diff > tol) begin
			$display("Mismatch at %0t: %s got %0d, expected %0.1f (tolerance %0.1f)",
				$time, name, got, exp, tol);
			abort_run();
		end
	endtask

	task automatic check_output(pending_t p);
		int  ph;
		real theta;
		real xr;
		real xi;
		real er;
		real ei;
		real tol;
		ph = expected_phase(p.k, p.n);
		compare_exact("dout[0]", dout[0], p.din[0]);
		for (int m = 1; m < `LANES; m++) begin
			theta = 2.0 * PI * real'(m * ph) / 65536.0;
			xr = real'(p.din[m].re);
			xi = real'(p.din[m].im);
			// (xr + j*xi) * (cos - j*sin)
			er = xr * $cos(theta) + xi * $sin(theta);
			ei = xi * $cos(theta) - xr * $sin(theta);
			tol = ((er < 0.0 ? -er : er) + (ei < 0.0 ? -ei : ei)) / 512.0 + 2.0;
			compare_near($sformatf("dout[%0d].re", m), dout[m].re, er, tol);
			compare_near($sformatf("dout[%0d].im", m), dout[m].im, ei, tol);
		end
	endtask

	task automatic apply_table();
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			@(posedge clk);
			in_val <= 1'b1;
			twdl_k <= STIM[i].k;
			twdl_n <= STIM[i].n;
			din    <= make_vector(i, STIM[i].rand_mode);
			for (int g = 0; g < int'(STIM[i].gap); g++) begin
				@(posedge clk);
				in_val <= 1'b0;
			end
		end
		@(posedge clk);
		in_val <= 1'b0;
	endtask

	// inputs and outputs are both stable at the falling edge
	initial begin : monitor
		pending_t entry;
		int       cyc;
		cyc = 0;
		forever begin
			@(negedge clk);
			if (twiddle_stage_inst.u_checker.assert_fails != 0) begin
				$display("a checker assertion failed before %0t", $time);
				abort_run();
			end
			if (out_val === 1'b1) begin
				if (pending.size() == 0) begin
					$display("out_val high at %0t with no vector in flight", $time);
					abort_run();
				end
				entry = pending.pop_front();
				if (entry.due != cyc) begin
					$display("Mismatch at %0t: out_val cycle got %0d, expected %0d",
						$time, cyc, entry.due);
					abort_run();
				end
				check_output(entry);
			end else if (out_val !== 1'b0) begin
				$display("out_val is unknown at %0t", $time);
				abort_run();
			end else if (pending.size() != 0 && pending[0].due <= cyc) begin
				$display("out_val missing at %0t for a vector due in cycle %0d",
					$time, pending[0].due);
				abort_run();
			end
			// the next edge resets the pipeline and drops everything in flight
			if (!rst_n) begin
				pending.delete();
			end else if (in_val) begin
				entry.due = cyc + `STAGE_LAT;
				entry.k   = twdl_k;
				entry.n   = twdl_n;
				entry.din = din;
				pending.push_back(entry);
			end
			cyc++;
		end
	end

	// two table passes and two resets plus the drain and some margin
	initial begin : watchdog
		int budget;
		budget = 2 * (NUM_ENTRIES + total_gaps() + 1) + 2 * RST_CYCLES + `STAGE_LAT + 50;
		repeat (budget) @(posedge clk);
		$display("timeout, the run did not finish within %0d cycles", budget);
		abort_run();
	end

	initial begin : driver
		void'($urandom(32'h37c43dca));
		rst_n  = 1'b0;
		in_val = 1'b0;
		twdl_k = '0;
		twdl_n = 12'd1;
		din    = '0;
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		apply_table();
		// reset while the tail of the pass is still in flight
		rst_n <= 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		apply_table();
		while (pending.size() != 0) begin
			@(negedge clk);
		end
		// any stray out_val here has no vector to match
		repeat (8) @(negedge clk);
		if (twiddle_stage_inst.u_checker.assert_fails == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* bench/twiddle_stage_checker.sv */
`timescale 1ns/1ps
`include "twiddle_config.svh"

module twiddle_stage_checker
	import twiddle_pkg::*;
(
	input logic        clk,
	input logic        rst_n,
	input logic        in_val,
	input logic        out_val,
	input sample_vec_t dout
);

	// edges since reset was last seen low, saturating
	int since_rst = 0;
	// polled by the testbench
	int assert_fails = 0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			since_rst <= 0;
		end else if (since_rst < `STAGE_LAT) begin
			since_rst <= since_rst + 1;
		end
	end

	// nothing can cross the pipeline this soon after reset
	quiet_after_reset: assert property (
		@(posedge clk) disable iff (!rst_n)
		(since_rst < `STAGE_LAT) |-> !out_val
	) else begin
		assert_fails++;
		$error("out_val high within the pipeline latency after reset");
	end

	fixed_latency: assert property (
		@(posedge clk) disable iff (!rst_n)
		(since_rst >= `STAGE_LAT) |-> (out_val == $past(in_val, `STAGE_LAT))
	) else begin
		assert_fails++;
		$error("out_val does not follow in_val by the stage latency");
	end

	known_output: assert property (
		@(posedge clk) disable iff (!rst_n)
		out_val |-> !$isunknown(dout)
	) else begin
		assert_fails++;
		$error("dout has unknown bits while out_val is high");
	end

endmodule

/* hdl/twiddle_stage.sv */
`timescale 1ns/1ps
`include "twiddle_config.svh"

module twiddle_stage
	import twiddle_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        in_val,
	input  tw_index_t   twdl_k,
	input  tw_index_t   twdl_n,
	input  sample_vec_t din,
	output logic        out_val,
	output sample_vec_t dout
);

	phase_t       phase;
	logic         phase_val;
	cplx_coef_t   w1;
	logic         w1_val;
	coef_vec_t    coefs;
	logic         coefs_val;
	sample_vec_t  dly_data;
	logic         dly_val;
	cplx_sample_t lane_y  [1:`LANES-1];
	cplx_sample_t lane0_q [0:`ROT_LAT-1];
	logic [`ROT_LAT-1:0] val_q;

	// coefficient path: k/N, then W1, then W1..W4
	phase_divider u_div (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_val    (in_val),
		.k         (twdl_k),
		.n         (twdl_n),
		.phase     (phase),
		.phase_val (phase_val)
	);

	cordic_twiddle_gen u_cordic (
		.clk       (clk),
		.rst_n     (rst_n),
		.phase     (phase),
		.phase_val (phase_val),
		.w1        (w1),
		.w1_val    (w1_val)
	);

	twiddle_powers u_pow (
		.clk       (clk),
		.rst_n     (rst_n),
		.w1        (w1),
		.w1_val    (w1_val),
		.coefs     (coefs),
		.coefs_val (coefs_val)
	);

	// samples wait for their own coefficients
	sample_delay #(
		.DEPTH (`COEF_LAT)
	) u_dly (
		.clk     (clk),
		.rst_n   (rst_n),
		.din     (din),
		.in_val  (in_val),
		.dout    (dly_data),
		.out_val (dly_val)
	);

	for (genvar m = 1; m < `LANES; m++) begin : g_lane
		complex_rotator u_rot (
			.clk   (clk),
			.rst_n (rst_n),
			.x     (dly_data[m]),
			.w     (coefs[m]),
			.y     (lane_y[m])
		);
	end

	// lane 0 only matches the rotator latency
	always_ff @(posedge clk) begin
		lane0_q[0] <= dly_data[0];
		for (int i = 1; i < `ROT_LAT; i++) begin
			lane0_q[i] <= lane0_q[i-1];
		end
	end

	// both paths run in step, a vector is valid when both agree
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			val_q <= '0;
		end else begin
			val_q <= {val_q[`ROT_LAT-2:0], dly_val & coefs_val};
		end
	end

	always_comb begin
		dout[0] = lane0_q[`ROT_LAT-1];
		for (int m = 1; m < `LANES; m++) begin
			dout[m] = lane_y[m];
		end
	end

	assign out_val = val_q[`ROT_LAT-1];

endmodule

/* hdl/complex_rotator.sv */
`timescale 1ns/1ps
`include "twiddle_config.svh"

module complex_rotator
	import twiddle_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  cplx_sample_t x,
	input  cplx_coef_t   w,
	output cplx_sample_t y
);

	localparam int PROD_W = `DATA_W + `COEF_W;
	localparam int SUM_W  = PROD_W + 1;

	logic signed [PROD_W-1:0] rr_q;
	logic signed [PROD_W-1:0] ii_q;
	logic signed [PROD_W-1:0] ri_q;
	logic signed [PROD_W-1:0] ir_q;
	logic signed [SUM_W-1:0]  re_q;
	logic signed [SUM_W-1:0]  im_q;

	// partial products
	always_ff @(posedge clk) begin
		rr_q <= x.re * w.re;
		ii_q <= x.im * w.im;
		ri_q <= x.re * w.im;
		ir_q <= x.im * w.re;
	end

	// full width real and imaginary parts
	always_ff @(posedge clk) begin
		re_q <= rr_q - ii_q;
		im_q <= ri_q + ir_q;
	end

	// half-up: bit 13 carries into the kept bits
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			y <= '0;
		end else begin
			y.re <= re_q[`COEF_FRAC +: `DATA_W]
				+ {{(`DATA_W-1){1'b0}}, re_q[`COEF_FRAC-1]};
			y.im <= im_q[`COEF_FRAC +: `DATA_W]
				+ {{(`DATA_W-1){1'b0}}, im_q[`COEF_FRAC-1]};
		end
	end

endmodule

/* hdl/sample_delay.sv */
`timescale 1ns/1ps
`include "twiddle_config.svh"

module sample_delay
	import twiddle_pkg::*;
#(
	parameter int DEPTH = `COEF_LAT
) (
	input  logic        clk,
	input  logic        rst_n,
	input  sample_vec_t din,
	input  logic        in_val,
	output sample_vec_t dout,
	output logic        out_val
);

	sample_vec_t      data_q [0:DEPTH-1];
	logic [DEPTH-1:0] val_q;

	always_ff @(posedge clk) begin
		data_q[0] <= din;
		for (int i = 1; i < DEPTH; i++) begin
			data_q[i] <= data_q[i-1];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			val_q <= '0;
		end else begin
			val_q[0] <= in_val;
			for (int i = 1; i < DEPTH; i++) begin
				val_q[i] <= val_q[i-1];
			end
		end
	end

	assign dout    = data_q[DEPTH-1];
	assign out_val = val_q[DEPTH-1];

endmodule

/* hdl/twiddle_powers.sv */
`timescale 1ns/1ps
`include "twiddle_config.svh"

module twiddle_powers
	import twiddle_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  cplx_coef_t w1,
	input  logic       w1_val,
	output coef_vec_t  coefs,
	output logic       coefs_val
);

	localparam int PROD_W = 2*`COEF_W + 1;

	cplx_coef_t w1_q;
	cplx_coef_t w2_q;
	logic       val_q;

	// Q2.14 complex product, truncated at bit 14
	function automatic cplx_coef_t cmul(input cplx_coef_t a, input cplx_coef_t b);
		logic signed [PROD_W-1:0] pr;
		logic signed [PROD_W-1:0] pi;
		cplx_coef_t               r;
		pr = a.re * b.re - a.im * b.im;
		pi = a.re * b.im + a.im * b.re;
		r.re = pr[`COEF_FRAC +: `COEF_W];
		r.im = pi[`COEF_FRAC +: `COEF_W];
		return r;
	endfunction

	// stage one, square W1 and keep a copy
	always_ff @(posedge clk) begin
		w1_q <= w1;
		w2_q <= cmul(w1, w1);
	end

	// stage two, all four leave together
	always_ff @(posedge clk) begin
		coefs[0] <= '0;
		coefs[1] <= w1_q;
		coefs[2] <= w2_q;
		coefs[3] <= cmul(w1_q, w2_q);
		coefs[4] <= cmul(w2_q, w2_q);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			val_q     <= 1'b0;
			coefs_val <= 1'b0;
		end else begin
			val_q     <= w1_val;
			coefs_val <= val_q;
		end
	end

endmodule

/* hdl/cordic_twiddle_gen.sv */
`timescale 1ns/1ps
`include "twiddle_config.svh"

module cordic_twiddle_gen
	import twiddle_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  phase_t     phase,
	input  logic       phase_val,
	output cplx_coef_t w1,
	output logic       w1_val
);

	localparam int NS    = `CORDIC_ITERS;
	localparam int GUARD = 4;
	localparam int XY_W  = `COEF_W + 2;
	localparam int ANG_W = `PHASE_W + GUARD;

	// 16384/1.647 with two extra fraction bits
	localparam logic signed [XY_W-1:0] X_INIT = 18'sd39791;

	// atan(2^-i) in units of 2^-20 turn
	localparam logic signed [ANG_W-1:0] ATAN [0:NS-1] = '{
		20'sd131072, 20'sd77376, 20'sd40884, 20'sd20753,
		20'sd10417,  20'sd5213,  20'sd2607,  20'sd1304,
		20'sd652,    20'sd326,   20'sd163,   20'sd81,
		20'sd41,     20'sd20
	};

	logic signed [XY_W-1:0]  x_q    [0:NS];
	logic signed [XY_W-1:0]  y_q    [0:NS];
	logic signed [ANG_W-1:0] z_q    [0:NS-1];
	logic [1:0]              quad_q [0:NS];
	logic [NS:0]             val_q;

	logic signed [XY_W-1:0] x_rnd;
	logic signed [XY_W-1:0] y_rnd;
	coef_t                  c;
	coef_t                  s;

	// fold into the first quadrant, start on the real axis
	always_ff @(posedge clk) begin
		x_q[0]    <= X_INIT;
		y_q[0]    <= '0;
		z_q[0]    <= {2'b00, phase[`PHASE_W-3:0], {GUARD{1'b0}}};
		quad_q[0] <= phase[`PHASE_W-1 -: 2];
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			val_q[0] <= 1'b0;
		end else begin
			val_q[0] <= phase_val;
		end
	end

	for (genvar i = 0; i < NS; i++) begin : g_iter
		// rotate toward zero residual angle
		always_ff @(posedge clk) begin
			if (!z_q[i][ANG_W-1]) begin
				x_q[i+1] <= x_q[i] - (y_q[i] >>> i);
				y_q[i+1] <= y_q[i] + (x_q[i] >>> i);
			end else begin
				x_q[i+1] <= x_q[i] + (y_q[i] >>> i);
				y_q[i+1] <= y_q[i] - (x_q[i] >>> i);
			end
			quad_q[i+1] <= quad_q[i];
		end

		if (i < NS-1) begin : g_angle
			always_ff @(posedge clk) begin
				z_q[i+1] <= z_q[i][ANG_W-1] ? z_q[i] + ATAN[i] : z_q[i] - ATAN[i];
			end
		end

		always_ff @(posedge clk) begin
			if (!rst_n) begin
				val_q[i+1] <= 1'b0;
			end else begin
				val_q[i+1] <= val_q[i];
			end
		end
	end

	// drop the guard bits with rounding
	always_comb begin
		x_rnd = x_q[NS] + 18'sd2;
		y_rnd = y_q[NS] + 18'sd2;
		c = x_rnd[XY_W-1:2];
		s = y_rnd[XY_W-1:2];
	end

	// quadrant restore, W = cos - j*sin
	always_ff @(posedge clk) begin
		case (quad_q[NS])
			2'd0: begin
				w1.re <= c;
				w1.im <= -s;
			end
			2'd1: begin
				w1.re <= -s;
				w1.im <= -c;
			end
			2'd2: begin
				w1.re <= -c;
				w1.im <= s;
			end
			default: begin
				w1.re <= s;
				w1.im <= c;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			w1_val <= 1'b0;
		end else begin
			w1_val <= val_q[NS];
		end
	end

endmodule

/* hdl/phase_divider.sv */
`timescale 1ns/1ps
`include "twiddle_config.svh"

module phase_divider
	import twiddle_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      in_val,
	input  tw_index_t k,
	input  tw_index_t n,
	output phase_t    phase,
	output logic      phase_val
);

	// remainder and divisor only needed up to the next to last stage
	tw_index_t          rem_q [0:`DIV_LAT-2];
	tw_index_t          den_q [0:`DIV_LAT-2];
	phase_t             quo_q [0:`DIV_LAT-1];
	logic [`DIV_LAT-1:0] val_q;

	for (genvar s = 0; s < `DIV_LAT; s++) begin : g_stage
		tw_index_t      rem_in;
		tw_index_t      den_in;
		phase_t         quo_in;
		logic           val_in;
		logic [`TW_W:0] shifted;
		logic [`TW_W:0] diff;
		logic           ge;
		phase_t         quo_next;

		if (s == 0) begin : g_first
			// k < n, so the first remainder is k itself
			assign rem_in = k;
			assign den_in = n;
			assign quo_in = '0;
			assign val_in = in_val;
		end else begin : g_next
			assign rem_in = rem_q[s-1];
			assign den_in = den_q[s-1];
			assign quo_in = quo_q[s-1];
			assign val_in = val_q[s-1];
		end

		// one restoring step, quotient bits msb first
		always_comb begin
			shifted = {rem_in, 1'b0};
			diff = shifted - {1'b0, den_in};
			ge = shifted >= {1'b0, den_in};
			quo_next = quo_in;
			quo_next[`PHASE_W-1-s] = ge;
		end

		always_ff @(posedge clk) begin
			quo_q[s] <= quo_next;
		end

		if (s < `DIV_LAT-1) begin : g_carry
			always_ff @(posedge clk) begin
				rem_q[s] <= ge ? diff[`TW_W-1:0] : shifted[`TW_W-1:0];
				den_q[s] <= den_in;
			end
		end

		always_ff @(posedge clk) begin
			if (!rst_n) begin
				val_q[s] <= 1'b0;
			end else begin
				val_q[s] <= val_in;
			end
		end
	end

	assign phase     = quo_q[`DIV_LAT-1];
	assign phase_val = val_q[`DIV_LAT-1];

endmodule

/* hdl/twiddle_pkg.sv */
`include "twiddle_config.svh"

package twiddle_pkg;

	// scalar widths
	typedef logic signed [`DATA_W-1:0]  sample_t;
	typedef logic signed [`COEF_W-1:0]  coef_t;
	typedef logic        [`TW_W-1:0]    tw_index_t;
	typedef logic        [`PHASE_W-1:0] phase_t;

	// complex sample
	typedef struct packed {
		sample_t re;
		sample_t im;
	} cplx_sample_t;

	// complex coefficient in Q2.14
	typedef struct packed {
		coef_t re;
		coef_t im;
	} cplx_coef_t;

	// one butterfly output, lane 0 at index 0
	typedef cplx_sample_t [`LANES-1:0] sample_vec_t;

	// entry 0 unused, keeps lane numbering
	typedef cplx_coef_t [`LANES-1:0] coef_vec_t;

endpackage

/* hdl/twiddle_config.svh */
`ifndef TWIDDLE_CONFIG_SVH
`define TWIDDLE_CONFIG_SVH

// sample and coefficient widths
`define DATA_W       30
`define COEF_W       16
`define COEF_FRAC    14

// twiddle index and phase resolution
`define TW_W         12
`define PHASE_W      16

// radix-5 vector
`define LANES        5

`define CORDIC_ITERS 14

// pipeline latencies in clock cycles
`define DIV_LAT      16
`define CORDIC_LAT   16
`define POW_LAT      2
`define COEF_LAT     (`DIV_LAT + `CORDIC_LAT + `POW_LAT)
`define ROT_LAT      3
`define STAGE_LAT    (`COEF_LAT + `ROT_LAT)

`endif
